// File: board_pkg.sv
// Divider defaults assume a 50 MHz soc_clk; the register bus is fixed at 32-bit address and data
package board_pkg;

  ////////////////////
  // Register bus
  ////////////////////

  localparam int unsigned REG_ADDR_W = 32;
  localparam int unsigned REG_DATA_W = 32;

  // Read data returned by the error responder
  localparam logic [REG_DATA_W-1:0] REG_ERR_VAL = 32'hBADCAB1E;

  ////////////////////
  // Fan and SPI pads
  ////////////////////

  localparam int unsigned FAN_SET_W = 4;
  // One PWM slot per switch step
  localparam int FAN_STEPS = 16;

  localparam int unsigned SPI_CS_W = 2;
  localparam int unsigned SPI_SD_W = 4;

  ////////////////////
  // Divider defaults
  ////////////////////

  // 50 MHz down to 1 MHz
  localparam int RTC_DIV_DEFAULT  = 50;
  localparam int FAN_SLOT_DEFAULT = 256;

endpackage

// File: board_rst_sync.sv
// Needs a running soc_clk to release reset; test_mode_i bypasses the flops entirely
module board_rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic soc_rst_no
);

  logic [1:0] sync_q;

  // Assert at once, release after two soc_clk edges
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan mode hands the pad reset straight through
  assign soc_rst_no = test_mode_i ? rst_n : sync_q[1];

  ////////////////////
  // Checks
  ////////////////////

  // Internal reset may only leave reset once the pad reset is gone
  a_no_early_release: assert property (
    @(posedge soc_clk) $rose(soc_rst_no) |-> rst_n
  ) else $error("soc_rst_no released while rst_n low");

endmodule

// File: rtc_clk_div.sv
// RTC_DIV must be even and at least 2; output is a divided data signal, not a buffered clock
module rtc_clk_div
  import board_pkg::*;
#(
  parameter int RTC_DIV = RTC_DIV_DEFAULT
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o
);

  localparam int HALF  = RTC_DIV / 2;
  localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

  if ((RTC_DIV < 2) || (RTC_DIV % 2 != 0)) begin : g_bad_div
    $error("rtc_clk_div: RTC_DIV must be even and >= 2");
  end

  logic [CNT_W-1:0] cnt_q;
  logic             half_done;
  logic             rtc_q;

  assign half_done = (cnt_q == CNT_W'(HALF - 1));

  // Toggle once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= half_done ? '0 : cnt_q + 1'b1;
      if (half_done) begin
        rtc_q <= ~rtc_q;
      end
    end
  end

  assign rtc_clk_o = rtc_q;

  // Counter never runs past the half period
  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n) int'(cnt_q) < HALF
  ) else $error("RTC divider counter out of range");

endmodule

// File: fan_pwm_ctrl.sv
// First PWM period after reset runs at zero duty; switch changes take effect at the next period
module fan_pwm_ctrl
  import board_pkg::*;
#(
  parameter int FAN_SLOT_CYCLES = FAN_SLOT_DEFAULT
) (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic [FAN_SET_W-1:0] fan_set_i,
  output logic                 fan_pwm_o
);

  localparam int PRE_W  = (FAN_SLOT_CYCLES > 1) ? $clog2(FAN_SLOT_CYCLES) : 1;
  localparam int SLOT_W = $clog2(FAN_STEPS);

  logic [PRE_W-1:0]     pre_d, pre_q;
  logic [SLOT_W-1:0]    slot_d, slot_q;
  logic [FAN_SET_W-1:0] set_d, set_q;
  logic                 slot_tick;
  logic                 period_end;
  logic                 pwm_d, pwm_q;

  ////////////////////
  // Slot timing
  ////////////////////

  assign slot_tick  = (pre_q == PRE_W'(FAN_SLOT_CYCLES - 1));
  assign period_end = slot_tick && (slot_q == SLOT_W'(FAN_STEPS - 1));

  always_comb begin
    pre_d  = slot_tick ? '0 : pre_q + 1'b1;
    slot_d = slot_q;
    if (slot_tick) begin
      slot_d = period_end ? '0 : slot_q + 1'b1;
    end
    // New setting lands together with slot 0
    set_d  = period_end ? fan_set_i : set_q;
    // Compare on next-state values so the output lines up with slot_q
    pwm_d  = (slot_d < set_d);
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      slot_q <= '0;
      set_q  <= '0;
      pwm_q  <= 1'b0;
    end else begin
      pre_q  <= pre_d;
      slot_q <= slot_d;
      set_q  <= set_d;
      pwm_q  <= pwm_d;
    end
  end

  assign fan_pwm_o = pwm_q;

  // Fan stays off for a zero setting
  a_off_at_zero: assert property (
    @(posedge soc_clk) disable iff (!rst_n) (set_q == '0) |-> !fan_pwm_o
  ) else $error("fan PWM high with zero setting");

endmodule

// File: reg_err_responder.sv
// Answers every access with an error one cycle later; address and write data are never decoded
module reg_err_responder
  import board_pkg::*;
(
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  write_i,
  input  logic [REG_ADDR_W-1:0] addr_i,
  input  logic [REG_DATA_W-1:0] wdata_i,
  output logic                  rsp_o,
  output logic                  error_o,
  output logic [REG_DATA_W-1:0] rdata_o
);

  logic                  rsp_q;
  logic [REG_DATA_W-1:0] rdata_q;

  // One response per request
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      rsp_q   <= req_i;
      // Reads see the error word, writes read back zero
      rdata_q <= (req_i && !write_i) ? REG_ERR_VAL : '0;
    end
  end

  // Every response is an error response
  assign rsp_o   = rsp_q;
  assign error_o = rsp_q;
  assign rdata_o = rdata_q;

  ////////////////////
  // Checks
  ////////////////////

  a_rsp_after_req: assert property (
    @(posedge soc_clk) disable iff (!rst_n) rsp_o |-> $past(req_i)
  ) else $error("response without request");

  // Master must present a clean request even though it is ignored
  a_req_known: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
      req_i |-> !$isunknown({write_i, addr_i}) && (!write_i || !$isunknown(wdata_i))
  ) else $error("register request with unknown fields");

endmodule

// File: board_glue_top.sv
// Only chip select 0 and data line 0 reach the SD card; SD pins are driven push-pull, no tristates
module board_glue_top
  import board_pkg::*;
#(
  parameter int RTC_DIV         = RTC_DIV_DEFAULT,
  parameter int FAN_SLOT_CYCLES = FAN_SLOT_DEFAULT
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  test_mode_i,

  // Fan
  input  logic [FAN_SET_W-1:0]  fan_sw_i,
  output logic                  fan_pwm_o,

  // RTC
  output logic                  rtc_clk_o,

  // SPI host side
  input  logic                  spi_sck_i,
  input  logic                  spi_sck_en_i,
  input  logic [SPI_CS_W-1:0]   spi_cs_i,
  input  logic [SPI_CS_W-1:0]   spi_cs_en_i,
  input  logic [SPI_SD_W-1:0]   spi_sd_i,
  input  logic [SPI_SD_W-1:0]   spi_sd_en_i,
  output logic [SPI_SD_W-1:0]   spi_sd_o,

  // SD card pads
  output logic                  sd_sclk_o,
  output logic                  sd_cs_o,
  output logic                  sd_cmd_o,
  output logic [1:0]            sd_dat_unused_o,
  input  logic                  sd_dat0_i,

  // Register bus
  input  logic                  reg_req_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [REG_DATA_W-1:0] reg_wdata_i,
  output logic                  reg_rsp_o,
  output logic [REG_DATA_W-1:0] reg_rdata_o,
  output logic                  reg_error_o
);

  logic soc_rst_n;

  ////////////////////
  // Reset
  ////////////////////

  board_rst_sync i_rst_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_no  ( soc_rst_n   )
  );

  ////////////////////
  // SD card, SPI mode
  ////////////////////

  // Idle high when the host is not driving
  assign sd_sclk_o = spi_sck_en_i   ? spi_sck_i   : 1'b1;
  // Chip select goes out on DAT3
  assign sd_cs_o   = spi_cs_en_i[0] ? spi_cs_i[0] : 1'b1;
  // MOSI on CMD
  assign sd_cmd_o  = spi_sd_en_i[0] ? spi_sd_i[0] : 1'b1;

  // DAT1 and DAT2 unused in SPI mode
  assign sd_dat_unused_o = 2'b11;

  // MISO comes back from DAT0
  always_comb begin
    spi_sd_o    = '0;
    spi_sd_o[1] = sd_dat0_i;
  end

  ////////////////////
  // RTC and fan
  ////////////////////

  rtc_clk_div #(
    .RTC_DIV ( RTC_DIV )
  ) i_rtc_clk_div (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .rtc_clk_o ( rtc_clk_o )
  );

  fan_pwm_ctrl #(
    .FAN_SLOT_CYCLES ( FAN_SLOT_CYCLES )
  ) i_fan_pwm_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .fan_set_i ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////
  // Register bus
  ////////////////////

  reg_err_responder i_reg_err (
    .soc_clk ( soc_clk     ),
    .rst_n   ( soc_rst_n   ),
    .req_i   ( reg_req_i   ),
    .write_i ( reg_write_i ),
    .addr_i  ( reg_addr_i  ),
    .wdata_i ( reg_wdata_i ),
    .rsp_o   ( reg_rsp_o   ),
    .error_o ( reg_error_o ),
    .rdata_o ( reg_rdata_o )
  );

endmodule

// File: tb_clk_gen.sv
// Free-running clock from time zero; reset is released with a non-blocking update on a rising edge
module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 4
) (
  output logic soc_clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    soc_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) soc_clk = ~soc_clk;
  end

  // Hold reset for a fixed number of rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge soc_clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tb_board_glue.sv
// Uses RTC_DIV 10 and FAN_SLOT_CYCLES 2; all outputs are sampled on the falling clock edge
module tb_board_glue
  import board_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RTC_DIV      = 10;
  localparam int          FAN_SLOT_CYC = 2;
  localparam int          RST_CYCLES   = 4;
  localparam int          SYNC_EDGES   = 2;
  localparam int          RTC_WINDOW   = 40;
  localparam int          FAN_PERIOD   = FAN_STEPS * FAN_SLOT_CYC;
  localparam int          SD_ENTRIES   = 24;
  localparam int          DRAIN        = 4;
  localparam logic [31:0] SEED         = 32'h1c9c262d;

  typedef enum {K_REG, K_SD, K_FAN} kind_e;

  // Register entries use stim[0] as the write flag and SD entries pack the pad inputs
  // in stim[14:0]; fan entries carry the setting in stim
  typedef struct {
    kind_e       kind;
    logic [31:0] stim;
    logic [31:0] exp;
    bit          b2b;
  } entry_t;

  logic soc_clk, rst_n, test_mode_i;
  logic [FAN_SET_W-1:0] fan_sw_i;
  logic fan_pwm_o, rtc_clk_o;
  logic spi_sck_i, spi_sck_en_i;
  logic [SPI_CS_W-1:0] spi_cs_i, spi_cs_en_i;
  logic [SPI_SD_W-1:0] spi_sd_i, spi_sd_en_i, spi_sd_o;
  logic sd_sclk_o, sd_cs_o, sd_cmd_o, sd_dat0_i;
  logic [1:0] sd_dat_unused_o;
  logic reg_req_i, reg_write_i, reg_rsp_o, reg_error_o;
  logic [REG_ADDR_W-1:0] reg_addr_i;
  logic [REG_DATA_W-1:0] reg_wdata_i, reg_rdata_o;

  entry_t      tab[$];
  logic [31:0] exp_q[$];
  bit          rsp_due = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(RST_CYCLES)) clk_gen_i (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   )
  );

  board_glue_top #(.RTC_DIV(RTC_DIV), .FAN_SLOT_CYCLES(FAN_SLOT_CYC)) dut_i (.*);

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input kind_e k, input logic [31:0] stim, input logic [31:0] exp,
                           input bit b2b);
    entry_t e;
    e.kind = k;
    e.stim = stim;
    e.exp  = exp;
    e.b2b  = b2b;
    tab.push_back(e);
  endtask

  // SPI mode pad rule with outputs packed as {spi_sd_o, dat_unused, cmd, cs, sclk}
  function automatic logic [31:0] sd_expect(input logic [14:0] s);
    logic       sck, sck_en, dat0;
    logic [1:0] cs, cs_en;
    logic [3:0] sd, sd_en;
    logic [31:0] e;
    {dat0, sd_en, sd, cs_en, cs, sck_en, sck} = s;
    e      = '0;
    e[0]   = sck_en ? sck : 1'b1;
    e[1]   = cs_en[0] ? cs[0] : 1'b1;
    e[2]   = sd_en[0] ? sd[0] : 1'b1;
    e[4:3] = 2'b11;
    e[8:5] = {2'b00, dat0, 1'b0};
    return e;
  endfunction

  task automatic apply_reg(input entry_t e);
    @(posedge soc_clk);
    reg_req_i   <= 1'b1;
    reg_write_i <= e.stim[0];
    reg_addr_i  <= $urandom;
    reg_wdata_i <= $urandom;
    exp_q.push_back(e.exp);
    // Back-to-back entries keep the strobe high into the next request
    if (!e.b2b) begin
      @(posedge soc_clk);
      reg_req_i <= 1'b0;
    end
  endtask

  task automatic apply_sd(input entry_t e);
    logic [31:0] got;
    @(posedge soc_clk);
    {sd_dat0_i, spi_sd_en_i, spi_sd_i, spi_cs_en_i, spi_cs_i, spi_sck_en_i, spi_sck_i}
      <= e.stim[14:0];
    @(negedge soc_clk);
    got = {23'd0, spi_sd_o, sd_dat_unused_o, sd_cmd_o, sd_cs_o, sd_sclk_o};
    check_value("SD pad outputs", got, e.exp);
  endtask

  task automatic apply_fan(input entry_t e);
    int high_cnt;
    high_cnt = 0;
    @(posedge soc_clk);
    fan_sw_i <= e.stim[FAN_SET_W-1:0];
    // Two periods guarantee the new setting is latched
    repeat (2 * FAN_PERIOD) @(posedge soc_clk);
    repeat (FAN_PERIOD) begin
      @(negedge soc_clk);
      if (fan_pwm_o) high_cnt++;
    end
    check_value($sformatf("fan high cycles, setting %0d", e.stim), high_cnt, e.exp);
  endtask

  task automatic check_rtc();
    int high_cnt;
    high_cnt = 0;
    @(posedge rst_n);
    // Internal release after SYNC_EDGES, then half a divider period
    repeat (SYNC_EDGES + RTC_DIV / 2 - 1) @(posedge soc_clk);
    @(negedge soc_clk);
    check_value("rtc_clk_o before first rise", rtc_clk_o, 32'd0);
    @(negedge soc_clk);
    check_value("rtc_clk_o at first rise", rtc_clk_o, 32'd1);
    repeat (RTC_WINDOW) begin
      @(negedge soc_clk);
      if (rtc_clk_o) high_cnt++;
    end
    check_value("rtc_clk_o high cycles", high_cnt, RTC_WINDOW / 2);
  endtask

  ////////////////////
  // Register response monitor
  ////////////////////

  always @(negedge soc_clk) begin
    if (rst_n) begin
      check_value("reg_rsp_o", reg_rsp_o, rsp_due);
      check_value("reg_error_o", reg_error_o, rsp_due);
      if (rsp_due) begin
        check_value("reg_rdata_o", reg_rdata_o, exp_q.pop_front());
      end
      rsp_due = reg_req_i;
    end
  end

  always @(posedge soc_clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [31:0] stim;
    int          fan_set[3];
    void'($urandom(SEED));
    fan_set = '{0, 5, 15};
    test_mode_i = 1'b0;
    fan_sw_i = '0;
    {spi_sck_i, spi_sck_en_i, spi_cs_i, spi_cs_en_i} = '0;
    {spi_sd_i, spi_sd_en_i, sd_dat0_i} = '0;
    {reg_req_i, reg_write_i, reg_addr_i, reg_wdata_i} = '0;

    // Single read, single write, then read, write, read back to back
    add_entry(K_REG, 32'd0, REG_ERR_VAL, 1'b0);
    add_entry(K_REG, 32'd1, 32'd0, 1'b0);
    add_entry(K_REG, 32'd0, REG_ERR_VAL, 1'b1);
    add_entry(K_REG, 32'd1, 32'd0, 1'b1);
    add_entry(K_REG, 32'd0, REG_ERR_VAL, 1'b0);
    for (int i = 0; i < SD_ENTRIES; i++) begin
      stim = $urandom & 32'h7fff;
      add_entry(K_SD, stim, sd_expect(stim[14:0]), 1'b0);
    end
    foreach (fan_set[i]) begin
      add_entry(K_FAN, fan_set[i], fan_set[i] * FAN_SLOT_CYC, 1'b0);
    end
    cycle_limit = 2 * (tab.size() + RST_CYCLES + SYNC_EDGES + RTC_DIV / 2 + RTC_WINDOW)
                + $size(fan_set) * 3 * FAN_PERIOD + DRAIN;

    // Outputs while reset is held
    @(posedge soc_clk);
    @(negedge soc_clk);
    check_value("rtc_clk_o in reset", rtc_clk_o, 32'd0);
    check_value("fan_pwm_o in reset", fan_pwm_o, 32'd0);
    check_value("reg_rsp_o in reset", reg_rsp_o, 32'd0);
    check_value("reg_error_o in reset", reg_error_o, 32'd0);

    check_rtc();
    foreach (tab[i]) begin
      case (tab[i].kind)
        K_REG:   apply_reg(tab[i]);
        K_SD:    apply_sd(tab[i]);
        default: apply_fan(tab[i]);
      endcase
    end
    repeat (DRAIN) @(posedge soc_clk);

    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("Some register requests never received a response");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
board_pkg.sv
board_rst_sync.sv
rtc_clk_div.sv
fan_pwm_ctrl.sv
reg_err_responder.sv
board_glue_top.sv
tb_clk_gen.sv
tb_board_glue.sv

// File: run_sim.sh
#!/bin/sh
# Run from the project root; exits non-zero unless the log holds the pass line
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_board_glue -f sim.f \
  && ./obj_dir/Vtb_board_glue | tee sim.log
grep -qx "test passed" sim.log \
  && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }
